//--- logic/replica_pkg.sv
`default_nettype none

package replica_pkg;

    localparam int node_num = 4;

    localparam int exp_steps      = 3;
    localparam int shift_per_step = 8;
    localparam int beta_frac      = 8;

    localparam int shift_cap = 23;             // a full right shift of the weight register.

    typedef logic signed [31:0] total_data_t;
    typedef logic [22:0]        weight_t;
    typedef logic [15:0]        beta_t;

    localparam weight_t weight_one = 23'h40_0000;  // 1.0 in weight units, that is 2^22.

    typedef enum logic [1:0] {
        NOP,
        SELF,
        PREV,
        FOLW
    } exchange_command_t;

    typedef enum logic {
        RUN,
        THR
    } opt_com_t;

    typedef enum logic [2:0] {
        IDLE,
        INIT,
        EXP,
        FIN,
        SWAP,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/exchange_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exchange_if;
    import replica_pkg::*;

    logic     opt_run;
    opt_com_t com;
    logic     phase;          // 0 pairs (0,1) and (2,3), 1 pairs (1,2).
    logic     exp_init;
    logic     exp_run;
    logic     exp_fin;
    weight_t  r_exchange;
    beta_t    beta;

    modport ctrl (
        output opt_run, com, phase,
        output exp_init, exp_run, exp_fin,
        output r_exchange, beta
    );

    modport node (
        input opt_run, com, phase,
        input exp_init, exp_run, exp_fin,
        input r_exchange, beta
    );

endinterface

`default_nettype wire

//--- logic/exchange_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exchange_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 thr,
    output logic                 done,
    exchange_if.ctrl             ex,
    input  replica_pkg::weight_t r_exchange_in,
    input  replica_pkg::beta_t   beta_in
);
    import replica_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic [1:0]  step_cnt;
    logic        start_ok;
    logic        phase;
    opt_com_t    com;
    weight_t     r_exchange;
    beta_t       beta;

    assign start_ok = (state == IDLE) && start;  // a start while busy is dropped.

    always_comb begin
        state_next = state;
        case (state)
            IDLE: if (start_ok) state_next = INIT;
            INIT: state_next = EXP;
            EXP: begin
                if (step_cnt == 2'(exp_steps - 1)) begin
                    state_next = FIN;
                end
            end
            FIN:  state_next = SWAP;
            SWAP: state_next = DONE;
            DONE: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            step_cnt <= '0;
            phase    <= 1'b0;
            com      <= RUN;
        end else begin
            state <= state_next;
            if (state == EXP) begin
                step_cnt <= step_cnt + 2'd1;
            end else begin
                step_cnt <= '0;
            end
            if (state == DONE) begin
                phase <= ~phase;                   // even and odd sweeps alternate.
            end
            if (start_ok) begin
                com <= thr ? THR : RUN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            r_exchange <= r_exchange_in;
            beta       <= beta_in;
        end
    end

    assign ex.exp_init   = (state == INIT);
    assign ex.exp_run    = (state == EXP);
    assign ex.exp_fin    = (state == FIN);
    assign ex.opt_run    = (state == SWAP);
    assign ex.com        = com;
    assign ex.phase      = phase;
    assign ex.r_exchange = r_exchange;
    assign ex.beta       = beta;
    assign done          = (state == DONE);

endmodule

`default_nettype wire

//--- logic/exp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exp_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    exchange_if.node                 ex,
    input  replica_pkg::total_data_t action,
    output replica_pkg::weight_t     weight
);
    import replica_pkg::*;

    logic [31:0] act_mag;
    logic [47:0] scaled;
    logic [4:0]  shift_load;
    logic [4:0]  shift_left;
    logic [4:0]  step;

    // the magnitude of -2^31 still fits as an unsigned value.
    assign act_mag = -action;
    assign scaled  = ({16'b0, act_mag} * {32'b0, ex.beta}) >> beta_frac;

    always_comb begin
        if (action >= 0) begin
            shift_load = '0;                       // a non-negative action gives full weight.
        end else if (scaled > 48'(shift_cap)) begin
            shift_load = 5'(shift_cap);
        end else begin
            shift_load = scaled[4:0];
        end
    end

    assign step = (shift_left > 5'(shift_per_step)) ? 5'(shift_per_step) : shift_left;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_left <= '0;
        end else if (ex.exp_init) begin
            shift_left <= shift_load;
        end else if (ex.exp_run) begin
            shift_left <= shift_left - step;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.exp_init) begin
            weight <= weight_one;
        end else if (ex.exp_run) begin
            weight <= weight >> step;
        end
    end

endmodule

`default_nettype wire

//--- logic/replica_node.sv
`timescale 1ns/1ps
`default_nettype none

module replica_node #(
    parameter int id = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    exchange_if.node                 ex,
    input  logic                     load,
    input  replica_pkg::total_data_t load_data,
    input  replica_pkg::total_data_t prev_data,
    input  replica_pkg::total_data_t folw_data,
    input  replica_pkg::weight_t     weight,
    output replica_pkg::total_data_t out_data,
    output replica_pkg::total_data_t action,
    output logic                     swapped
);
    import replica_pkg::*;

    localparam logic id_odd   = 1'(id % 2);
    localparam logic has_folw = (id + 1 < node_num);
    localparam logic has_prev = (id > 0);

    logic              is_lower;
    logic              is_upper;
    total_data_t       pair_action;
    total_data_t       action_l;
    logic              test;
    exchange_command_t cmd;
    total_data_t       next_data;

    // edge nodes drop out when their partner would lie outside the chain.
    assign is_lower = has_folw && (ex.phase == id_odd);
    assign is_upper = has_prev && (ex.phase != id_odd);

    assign pair_action = is_lower ? (folw_data - out_data) : (out_data - prev_data);
    assign action      = is_lower ? pair_action : '0;

    always_ff @(posedge clk) begin
        if (ex.exp_init) begin
            action_l <= pair_action;
        end
        if (ex.exp_fin) begin
            test <= (action_l >= 0) || (weight > ex.r_exchange);
        end
    end

    always_comb begin
        if (!ex.opt_run) begin
            cmd = NOP;
        end else if ((ex.com == THR) || !test) begin
            cmd = SELF;
        end else if (is_lower) begin
            cmd = FOLW;
        end else if (is_upper) begin
            cmd = PREV;
        end else begin
            cmd = SELF;                            // unpaired nodes hold their value.
        end
    end

    always_comb begin
        case (cmd)
            PREV:    next_data = prev_data;
            FOLW:    next_data = folw_data;
            default: next_data = out_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data <= '0;
            swapped  <= 1'b0;
        end else if (load) begin
            out_data <= load_data;
        end else if (cmd != NOP) begin
            out_data <= next_data;                 // all nodes move on the same edge.
            swapped  <= (cmd != SELF);
        end
    end

endmodule

`default_nettype wire

//--- logic/replica_array_top.sv
`timescale 1ns/1ps
`default_nettype none

module replica_array_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     thr,
    input  logic                     load,
    input  logic [1:0]               load_idx,
    input  logic [1:0]               rd_idx,
    input  replica_pkg::total_data_t load_data,
    input  replica_pkg::beta_t       beta,
    input  replica_pkg::weight_t     r_exchange,
    output logic                     done,
    output logic [3:0]               swaps,
    output replica_pkg::total_data_t rd_data
);
    import replica_pkg::*;

    exchange_if ex_bus ();

    total_data_t         node_data   [node_num];
    total_data_t         node_action [node_num];
    logic [node_num-1:0] node_swapped;
    total_data_t         exp_action;
    weight_t             weight;

    exchange_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .thr           (thr),
        .done          (done),
        .ex            (ex_bus),
        .r_exchange_in (r_exchange),
        .beta_in       (beta)
    );

    // the lower member of the first pair feeds the shared unit.
    assign exp_action = ex_bus.phase ? node_action[1] : node_action[0];

    exp_unit u_exp (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex     (ex_bus),
        .action (exp_action),
        .weight (weight)
    );

    for (genvar i = 0; i < node_num; i++) begin : g_node
        replica_node #(
            .id (i)
        ) u_node (
            .clk       (clk),
            .rst_n     (rst_n),
            .ex        (ex_bus),
            .load      (load && (load_idx == 2'(i))),
            .load_data (load_data),
            .prev_data (node_data[(i == 0) ? i : i - 1]),
            .folw_data (node_data[(i == node_num - 1) ? i : i + 1]),
            .weight    (weight),
            .out_data  (node_data[i]),
            .action    (node_action[i]),
            .swapped   (node_swapped[i])
        );
    end

    assign swaps   = node_swapped;
    assign rd_data = node_data[rd_idx];

endmodule

`default_nettype wire

//--- verification/replica_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module replica_asserts (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input logic                     done,
    input replica_pkg::ctrl_state_t state
);
    import replica_pkg::*;

    a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE && start) |=> (state == INIT))
        else $error("a start in IDLE did not move the controller to INIT");

    a_idle_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE && !start) |=> (state == IDLE))
        else $error("the controller left IDLE without a start");

    // three EXP cycles, then FIN, SWAP and DONE back to back.
    a_sweep_order: assert property (@(posedge clk) disable iff (!rst_n)
        (state == INIT) |=> (state == EXP) ##1 (state == EXP) ##1 (state == EXP)
            ##1 (state == FIN) ##1 (state == SWAP) ##1 (state == DONE) ##1 (state == IDLE))
        else $error("the sweep did not follow the INIT, EXP, FIN, SWAP, DONE order");

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IDLE && start) |-> ##7 done)
        else $error("done did not follow an accepted start by seven cycles");

endmodule

`default_nettype wire

//--- verification/replica_tb.sv
`timescale 1ns/1ps
`default_nettype none

module replica_tb;
    import replica_pkg::*;

    localparam int max_sweeps   = 64;
    localparam int reset_cycles = 10;
    localparam int sweep_budget = 20;   // cycles allowed per trace line.
    localparam int done_latency = 7;
    localparam int clk_period   = 8;
    localparam int full_shift   = 23;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        thr;
    logic        load;
    logic [1:0]  load_idx;
    logic [1:0]  rd_idx;
    total_data_t load_data;
    beta_t       beta;
    weight_t     r_exchange;
    logic        done;
    logic [3:0]  swaps;
    total_data_t rd_data;

    total_data_t tr_energy [max_sweeps][node_num];
    beta_t       tr_beta   [max_sweeps];
    weight_t     tr_r      [max_sweeps];
    logic        tr_thr    [max_sweeps];
    int          n_sweeps;
    logic        trace_ready;
    total_data_t expect_e [node_num];
    logic [3:0]  expect_swaps;
    int          err_energy;
    int          err_swaps;
    int          err_latency;
    int          err_other;

    replica_array_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .thr        (thr),
        .load       (load),
        .load_idx   (load_idx),
        .rd_idx     (rd_idx),
        .load_data  (load_data),
        .beta       (beta),
        .r_exchange (r_exchange),
        .done       (done),
        .swaps      (swaps),
        .rd_data    (rd_data)
    );

    bind exchange_ctrl replica_asserts u_asserts (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .done  (done),
        .state (state)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic check_energy(input string name, input total_data_t expected,
                                input total_data_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %0d actual %0d", name, expected, actual);
            err_energy++;
        end
    endtask

    task automatic check_swaps(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected %b actual %b", name, expected, actual);
            err_swaps++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("error: %s expected %0d actual %0d", name, expected, actual);
            err_latency++;
        end
    endtask

    // 2^22 shifted right by the capped count of (-action * beta) >> beta_frac.
    function automatic weight_t expected_weight(input total_data_t act, input beta_t b);
        longint count;
        longint full;
        full = 64'sd1 <<< 22;
        count = 0;
        if (act < 0) begin
            count = ((-longint'(act)) * longint'({48'd0, b})) >>> beta_frac;
            if (count > full_shift) count = full_shift;
        end
        return weight_t'(full >>> count);
    endfunction

    task automatic predict_sweep(input int s, input logic ph);
        total_data_t e [node_num];
        total_data_t act;
        weight_t     w;
        int          lo;
        for (int i = 0; i < node_num; i++) begin
            e[i] = tr_energy[s][i];
            expect_e[i] = e[i];
        end
        expect_swaps = 4'b0000;
        lo = ph ? 1 : 0;
        w = expected_weight(e[lo + 1] - e[lo], tr_beta[s]);   // the first pair sets the weight.
        if (!tr_thr[s]) begin
            for (int l = lo; l + 1 < node_num; l += 2) begin
                act = e[l + 1] - e[l];
                if (act >= 0 || w > tr_r[s]) begin
                    expect_e[l]         = e[l + 1];
                    expect_e[l + 1]     = e[l];
                    expect_swaps[l]     = 1'b1;
                    expect_swaps[l + 1] = 1'b1;
                end
            end
        end
    endtask

    task automatic read_trace();
        int    fd;
        int    code;
        string line;
        int    e0;
        int    e1;
        int    e2;
        int    e3;
        int    b;
        int    r;
        int    t;
        n_sweeps = 0;
        fd = $fopen("verification/exchange_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            err_other++;
            return;
        end
        while (!$feof(fd) && n_sweeps < max_sweeps) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line, "%d %d %d %d %h %h %d", e0, e1, e2, e3, b, r, t);
                if (code == 7) begin
                    tr_energy[n_sweeps][0] = e0;
                    tr_energy[n_sweeps][1] = e1;
                    tr_energy[n_sweeps][2] = e2;
                    tr_energy[n_sweeps][3] = e3;
                    tr_beta[n_sweeps] = beta_t'(b);
                    tr_r[n_sweeps] = weight_t'(r);
                    tr_thr[n_sweeps] = (t != 0);
                    n_sweeps++;
                end
            end
        end
        $fclose(fd);
        if (n_sweeps == 0) begin
            $display("the trace file holds no sweeps");
            err_other++;
        end
    endtask

    task automatic check_readback(input string name);
        for (int i = 0; i < node_num; i++) begin
            rd_idx = 2'(i);
            #1;
            check_energy($sformatf("%s node %0d", name, i), expect_e[i], rd_data);
        end
    endtask

    task automatic load_energies(input int s);
        for (int i = 0; i < node_num; i++) begin
            @(posedge clk);
            #1;
            if (done !== 1'b0) begin
                $display("done was high while the array was idle for loading");
                err_other++;
            end
            load      = 1'b1;
            load_idx  = 2'(i);
            load_data = tr_energy[s][i];
            expect_e[i] = tr_energy[s][i];
        end
        @(posedge clk);
        #1;
        load = 1'b0;
        check_readback($sformatf("sweep %0d load", s));
    endtask

    task automatic run_sweep(input int s);
        int cycles;
        @(posedge clk);
        #1;
        start      = 1'b1;
        thr        = tr_thr[s];
        beta       = tr_beta[s];
        r_exchange = tr_r[s];
        @(posedge clk);
        #1;
        start      = 1'b0;
        beta       = '0;                  // the controller must hold its own copies.
        r_exchange = '1;
        cycles = 1;
        @(negedge clk);
        while (done !== 1'b1 && cycles < sweep_budget) begin
            @(posedge clk);
            #1;
            cycles++;
            start = (cycles == 3);        // a start in the middle of the sweep.
            thr   = ~tr_thr[s];
            @(negedge clk);
        end
        if (done !== 1'b1) begin
            $display("done did not arrive within %0d cycles of start in sweep %0d",
                     sweep_budget, s);
            err_other++;
        end else begin
            check_latency($sformatf("sweep %0d done latency", s), done_latency, cycles);
            check_swaps($sformatf("sweep %0d swap flags", s), expect_swaps, swaps);
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        thr   = 1'b0;
        if (done !== 1'b0) begin
            $display("done stayed high after sweep %0d", s);
            err_other++;
        end
        check_readback($sformatf("sweep %0d result", s));
    endtask

    initial begin
        logic ph;
        err_energy  = 0;
        err_swaps   = 0;
        err_latency = 0;
        err_other   = 0;
        trace_ready = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        thr         = 1'b0;
        load        = 1'b0;
        load_idx    = 2'd0;
        rd_idx      = 2'd0;
        load_data   = '0;
        beta        = '0;
        r_exchange  = '0;
        read_trace();
        trace_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (done !== 1'b0) begin
            $display("done is not low after reset");
            err_other++;
        end
        check_swaps("after reset swap flags", 4'b0000, swaps);
        for (int i = 0; i < node_num; i++) expect_e[i] = '0;
        check_readback("after reset");
        ph = 1'b0;
        for (int s = 0; s < n_sweeps; s++) begin
            load_energies(s);
            predict_sweep(s, ph);
            run_sweep(s);
            ph = ~ph;
        end
        $display("energy errors: %0d, swap flag errors: %0d, latency errors: %0d, other: %0d",
                 err_energy, err_swaps, err_latency, err_other);
        if (err_energy + err_swaps + err_latency + err_other == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (trace_ready === 1'b1);
        #((n_sweeps * sweep_budget + reset_cycles + 10) * clk_period);
        $display("timeout: the sweeps did not finish in the allotted time");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
logic/replica_pkg.sv
logic/exchange_if.sv
logic/exchange_ctrl.sv
logic/exp_unit.sv
logic/replica_node.sv
logic/replica_array_top.sv
verification/replica_asserts.sv
verification/replica_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module replica_tb -f src.f --Mdir obj_dir -o replica_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/replica_sim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

//--- verification/exchange_trace.txt
# columns: e0 e1 e2 e3 (signed decimal), beta (hex), r_exchange (hex), thr (0 or 1)
# each line is one sweep; the pairing starts even after reset and alternates.
10 20 30 40 0100 200000 0
5 1 9 7 0100 200000 0
100 90 50 48 0100 000800 0
0 50 20 0 0100 000000 0
7 3 1 2 0080 100000 0
1 2 3 4 0100 000000 1
-5 -20 300 200 0040 3f0000 0
1000 -1000 1000 0 0001 3fffff 0
0 -400000 0 0 ffff 000010 0
3 9 -6 2 0010 080000 0
4 3 2 1 0100 000000 1
50 60 40 30 0100 000003 0
